//--- all.f
hdl/cnn_weight_pkg.sv
hdl/fetch_pkg.sv
hdl/weight_rom.sv
hdl/rom_arbiter.sv
hdl/layer_dot_engine.sv
hdl/weight_subsystem_top.sv
verification/weight_subsystem_assert.sv
verification/weight_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Build the weight subsystem testbench with Verilator and run it.
# A run fails if the simulator exits with an error or the log holds the fail message.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module weight_subsystem_tb -f all.f

status=0
./obj_dir/Vweight_subsystem_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without errors"

//--- weights.hex
// One ROM row per line, 32-bit hex, lane 3 in the high byte and lane 0 in the low byte
// Rows 0-8 hold layer 0, rows 9-10 layer 1, rows 11-15 layer 2
12f37f80
0a8155c4
e71902fd
40bf08f8
33cc11ee
7e820190
fe036a96
25d94bb5
807f0cf4
11223344
c3a55a3c
05fb7789
9c64e01f
2ad648b8
0ff17090
5aa5d72e

//--- verification/weight_subsystem_tb.sv
/*
 * Testbench for the weight subsystem. It runs each layer on one engine,
 * both engines at once and an ignored restart, and compares every result
 * with a sum built from its own copy of the ROM image.
 */
`default_nettype none

module weight_subsystem_tb;

    // Longest any single wait may last, in clock cycles
    localparam int TIMEOUT_CYCLES = 200;

    logic clk;
    logic rst_n;
    logic [fetch_pkg::NUM_PORTS-1:0]                     start;
    cnn_weight_pkg::layer_t   [fetch_pkg::NUM_PORTS-1:0] layer;
    cnn_weight_pkg::act_vec_t [fetch_pkg::NUM_PORTS-1:0] act;
    logic [fetch_pkg::NUM_PORTS-1:0]                     busy;
    logic [fetch_pkg::NUM_PORTS-1:0]                     done;
    cnn_weight_pkg::acc_t     [fetch_pkg::NUM_PORTS-1:0] result;

    // Reference copy of the ROM contents
    cnn_weight_pkg::weight_vec_t rom_image [cnn_weight_pkg::ROM_DEPTH];
    // Sum expected from the job each port was started with
    cnn_weight_pkg::acc_t expected [fetch_pkg::NUM_PORTS];
    int seed;

    weight_subsystem_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .layer  (layer),
        .act    (act),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Dot product of a layer's in-range weights with the activation lanes
    function automatic cnn_weight_pkg::acc_t ref_sum(input int lyr,
                                                     input cnn_weight_pkg::act_vec_t a);
        int sum;
        int flat;
        logic signed [7:0] w;
        logic signed [7:0] x;
        sum = 0;
        for (int r = 0; r < cnn_weight_pkg::LAYER_VECTORS[lyr]; r++) begin
            for (int lane = 0; lane < cnn_weight_pkg::VECTOR_SIZE; lane++) begin
                flat = r * cnn_weight_pkg::VECTOR_SIZE + lane;
                // Lanes past the layer's weight count hold data of no layer
                if (flat < cnn_weight_pkg::LAYER_WEIGHTS[lyr]) begin
                    w = rom_image[cnn_weight_pkg::LAYER_OFFSETS[lyr] + r][lane*8 +: 8];
                    x = a[lane*8 +: 8];
                    sum = sum + int'(w) * int'(x);
                end
            end
        end
        return cnn_weight_pkg::acc_t'(sum);
    endfunction

    task automatic fail_now();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    // Compare one port's result, and its latency when one is given
    task automatic check_result(input int p, input int n, input int exp_cycles);
        assert (result[p] == expected[p]) else begin
            $display("MISMATCH at %0t: port %0d result %0d expected %0d",
                     $time, p, result[p], expected[p]);
            fail_now();
        end
        if (exp_cycles != 0) begin
            assert (n == exp_cycles) else begin
                $display("MISMATCH at %0t: port %0d done in cycle %0d expected %0d",
                         $time, p, n, exp_cycles);
                fail_now();
            end
        end
    endtask

    // Start the ports in mask and wait for each done. The start cycle is
    // cycle 1. A nonzero restart_at repeats start with new inputs then
    task automatic run_jobs(input logic [1:0] mask, input int exp_cycles,
                            input int restart_at);
        logic [1:0] pending;
        int n;
        pending = mask;
        for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
            if (mask[p]) begin
                expected[p] = ref_sum(int'(layer[p]), act[p]);
            end
        end
        start = mask;
        n = 1;
        while (pending != '0 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            start = '0;
            n++;
            // Every started engine is busy from the cycle after start
            if (n == 2) begin
                assert ((busy & mask) == mask) else begin
                    $display("MISMATCH at %0t: busy low after start", $time);
                    fail_now();
                end
            end
            if (n == restart_at) begin
                start = mask;
                for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
                    if (mask[p]) begin
                        layer[p] = cnn_weight_pkg::layer_t'((int'(layer[p]) + 1) % 3);
                        act[p]   = ~act[p];
                    end
                end
            end
            for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
                if (pending[p] && done[p]) begin
                    check_result(p, n, exp_cycles);
                    pending[p] = 1'b0;
                end
            end
        end
        if (pending != '0) begin
            $display("Timeout at %0t: no done from ports %b within %0d cycles",
                     $time, pending, TIMEOUT_CYCLES);
            fail_now();
        end
        // One cycle after done the engines are back in idle
        @(posedge clk);
        #1;
        assert ((busy & mask) == '0) else begin
            $display("MISMATCH at %0t: busy still high after done", $time);
            fail_now();
        end
    endtask

    initial begin
        seed  = 32'h2d22_9239;
        rst_n = 1'b0;
        start = '0;
        layer = '0;
        act   = '0;
        $readmemh("weights.hex", rom_image);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Nothing may move without a start
        repeat (5) begin
            @(posedge clk);
            #1;
            assert (busy == '0 && done == '0) else begin
                $display("MISMATCH at %0t: busy or done high with no start", $time);
                fail_now();
            end
        end

        // Engine 0 alone on every layer, latency fixed by the row count
        for (int l = 0; l < cnn_weight_pkg::NUM_LAYERS; l++) begin
            layer[0] = cnn_weight_pkg::layer_t'(l);
            act[0]   = $random(seed);
            run_jobs(2'b01, cnn_weight_pkg::LAYER_VECTORS[l] + 3, 0);
        end

        // Layer 2 ends in a half row, so all-nonzero activations expose the mask
        layer[0] = 2'd2;
        act[0]   = 32'h7f81_33c5;
        run_jobs(2'b01, cnn_weight_pkg::LAYER_VECTORS[2] + 3, 0);

        // Both engines start together on different layers
        layer[0] = 2'd0;
        layer[1] = 2'd2;
        act[0]   = $random(seed);
        act[1]   = $random(seed);
        run_jobs(2'b11, 0, 0);

        // Repeated contention on layer 0
        repeat (20) begin
            layer[0] = 2'd0;
            layer[1] = 2'd0;
            act[0]   = $random(seed);
            act[1]   = $random(seed);
            run_jobs(2'b11, 0, 0);
        end

        // A start on engine 1 while it is streaming must not disturb the job
        layer[1] = 2'd1;
        act[1]   = $random(seed);
        run_jobs(2'b10, cnn_weight_pkg::LAYER_VECTORS[1] + 3, 2);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/weight_subsystem_assert.sv
/*
 * Concurrent protocol checks for the weight subsystem, bound to the top level.
 * Covers grant exclusivity, grant-to-response timing, round-robin order and done.
 */
`default_nettype none

module weight_subsystem_assert (
    input logic                            clk,
    input logic                            rst_n,
    input logic [fetch_pkg::NUM_PORTS-1:0] req,
    input logic [fetch_pkg::NUM_PORTS-1:0] gnt,
    input logic [fetch_pkg::NUM_PORTS-1:0] rsp_valid,
    input logic [fetch_pkg::NUM_PORTS-1:0] busy,
    input logic [fetch_pkg::NUM_PORTS-1:0] done
);

    // The single ROM port can serve only one engine per cycle
    a_gnt_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(gnt[0] && gnt[1]))
        else $error("both ports granted in the same cycle");

    // A grant always answers a request
    a_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        (gnt & ~req) == '0)
        else $error("grant given to a port that is not requesting");

    for (genvar p = 0; p < fetch_pkg::NUM_PORTS; p++) begin : g_port
        // The ROM answers exactly one cycle after the grant
        a_rsp_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
            gnt[p] |=> rsp_valid[p])
            else $error("no response one cycle after grant on port %0d", p);

        a_rsp_has_gnt: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid[p] |-> $past(gnt[p]))
            else $error("response on port %0d without a grant before it", p);

        // With both engines still asking, the other port wins next
        a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
            (&req && gnt[p]) |=> (!(&req) || gnt[1-p]))
            else $error("port %0d granted twice in a row under contention", p);

        // done closes a running job one cycle after its last response
        a_done_in_job: assert property (@(posedge clk) disable iff (!rst_n)
            done[p] |-> $past(busy[p]) && $past(rsp_valid[p]))
            else $error("done on port %0d outside a job or not after its last response", p);
    end

endmodule

bind weight_subsystem_top weight_subsystem_assert assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .gnt       (gnt),
    .rsp_valid (rsp_valid),
    .busy      (busy),
    .done      (done)
);

`default_nettype wire

//--- hdl/weight_subsystem_top.sv
/*
 * Weight subsystem top level with two dot-product engines sharing one ROM
 * through a round-robin arbiter. Each engine has its own start, layer,
 * activation, busy, done and result slice.
 */
`default_nettype none

module weight_subsystem_top (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [fetch_pkg::NUM_PORTS-1:0]                       start,
    input  cnn_weight_pkg::layer_t   [fetch_pkg::NUM_PORTS-1:0]   layer,
    input  cnn_weight_pkg::act_vec_t [fetch_pkg::NUM_PORTS-1:0]   act,
    output logic [fetch_pkg::NUM_PORTS-1:0]                       busy,
    output logic [fetch_pkg::NUM_PORTS-1:0]                       done,
    output cnn_weight_pkg::acc_t     [fetch_pkg::NUM_PORTS-1:0]   result
);

    // Engine side of the arbiter
    logic [fetch_pkg::NUM_PORTS-1:0]                req;
    fetch_pkg::rom_req_t [fetch_pkg::NUM_PORTS-1:0] port_req;
    logic [fetch_pkg::NUM_PORTS-1:0]                gnt;
    logic [fetch_pkg::NUM_PORTS-1:0]                rsp_valid;
    fetch_pkg::rom_rsp_t                            rsp;

    // ROM side of the arbiter
    logic                rd;
    fetch_pkg::rom_req_t rd_req;
    logic                rd_valid;
    fetch_pkg::rom_rsp_t rd_rsp;

    layer_dot_engine engine_0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start[0]),
        .layer     (layer[0]),
        .act       (act[0]),
        .busy      (busy[0]),
        .done      (done[0]),
        .result    (result[0]),
        .req       (req[0]),
        .rom_req   (port_req[0]),
        .gnt       (gnt[0]),
        .rsp_valid (rsp_valid[0]),
        .rsp       (rsp)
    );

    layer_dot_engine engine_1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start[1]),
        .layer     (layer[1]),
        .act       (act[1]),
        .busy      (busy[1]),
        .done      (done[1]),
        .result    (result[1]),
        .req       (req[1]),
        .rom_req   (port_req[1]),
        .gnt       (gnt[1]),
        .rsp_valid (rsp_valid[1]),
        .rsp       (rsp)
    );

    rom_arbiter arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .port_req  (port_req),
        .gnt       (gnt),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rd        (rd),
        .rd_req    (rd_req),
        .rd_valid  (rd_valid),
        .rd_rsp    (rd_rsp)
    );

    weight_rom rom_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd       (rd),
        .rd_req   (rd_req),
        .rd_valid (rd_valid),
        .rd_rsp   (rd_rsp)
    );

endmodule

`default_nettype wire

//--- hdl/layer_dot_engine.sv
/*
 * One dot-product engine. A start pulse latches a layer and an activation
 * vector, every row of that layer is fetched through the arbiter, and the
 * masked lane products are summed. done pulses once the last row is in.
 */
`default_nettype none

module layer_dot_engine (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  cnn_weight_pkg::layer_t   layer,
    input  cnn_weight_pkg::act_vec_t act,
    output logic                     busy,
    output logic                     done,
    output cnn_weight_pkg::acc_t     result,
    output logic                     req,
    output fetch_pkg::rom_req_t      rom_req,
    input  logic                     gnt,
    input  logic                     rsp_valid,
    input  fetch_pkg::rom_rsp_t      rsp
);

    fetch_pkg::engine_state_e state;

    // Layer and activations captured at start
    cnn_weight_pkg::layer_t   layer_q;
    cnn_weight_pkg::act_vec_t act_q;
    // Next row to request and the last row of the layer
    cnn_weight_pkg::vec_addr_t next_row;
    cnn_weight_pkg::vec_addr_t last_row;

    // Running sum, also presented as the result
    cnn_weight_pkg::acc_t acc;
    // Sum of the lane products of the row now returning
    cnn_weight_pkg::acc_t row_sum;

    // Any state other than IDLE counts as busy, REPORT included
    assign busy = (state != fetch_pkg::IDLE);
    assign done = (state == fetch_pkg::REPORT);
    assign result = acc;

    // Requests are raised for the whole of STREAM, one row per grant
    assign req = (state == fetch_pkg::STREAM);
    assign rom_req.layer = layer_q;
    assign rom_req.addr = next_row;

    // Multiply each valid lane by its activation and add up the row
    always_comb begin
        cnn_weight_pkg::weight_t w;
        cnn_weight_pkg::act_t    a;
        row_sum = '0;
        for (int i = 0; i < cnn_weight_pkg::VECTOR_SIZE; i++) begin
            w = cnn_weight_pkg::weight_t'(
                    rsp.data[i*cnn_weight_pkg::WEIGHT_W +: cnn_weight_pkg::WEIGHT_W]);
            a = cnn_weight_pkg::act_t'(
                    act_q[i*cnn_weight_pkg::WEIGHT_W +: cnn_weight_pkg::WEIGHT_W]);
            if (rsp.mask[i]) begin
                // Both operands are signed so the product is sign-extended
                row_sum = row_sum + cnn_weight_pkg::acc_t'(w * a);
            end
        end
    end

    // Control FSM and the accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= fetch_pkg::IDLE;
            next_row <= '0;
            acc      <= '0;
        end else begin
            case (state)
                fetch_pkg::IDLE: begin
                    // A start outside IDLE is dropped
                    if (start) begin
                        state    <= fetch_pkg::STREAM;
                        next_row <= '0;
                        acc      <= '0;
                    end
                end
                fetch_pkg::STREAM: begin
                    // Responses for earlier rows can overlap new grants
                    if (rsp_valid) begin
                        acc <= acc + row_sum;
                    end
                    if (gnt) begin
                        next_row <= next_row + 1'b1;
                        if (next_row == last_row) begin
                            state <= fetch_pkg::DRAIN;
                        end
                    end
                end
                fetch_pkg::DRAIN: begin
                    // Only the last row is still in flight here
                    if (rsp_valid) begin
                        acc   <= acc + row_sum;
                        state <= fetch_pkg::REPORT;
                    end
                end
                fetch_pkg::REPORT: begin
                    state <= fetch_pkg::IDLE;
                end
                default: begin
                    state <= fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // Job parameters are loaded on an accepted start
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::IDLE && start) begin
            layer_q <= layer;
            act_q   <= act;
            if (layer < cnn_weight_pkg::NUM_LAYERS) begin
                last_row <= cnn_weight_pkg::vec_addr_t'(
                                cnn_weight_pkg::LAYER_VECTORS[layer] - 1);
            end else begin
                // Unknown layers fetch one row, which the ROM returns empty
                last_row <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rom_arbiter.sv
/*
 * Round-robin arbiter in front of the single ROM read port.
 * One requester wins each cycle and sees gnt in the same cycle, and the
 * ROM response a cycle later is steered back to it through rsp_valid.
 */
`default_nettype none

module rom_arbiter (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [fetch_pkg::NUM_PORTS-1:0]             req,
    input  fetch_pkg::rom_req_t [fetch_pkg::NUM_PORTS-1:0] port_req,
    output logic [fetch_pkg::NUM_PORTS-1:0]             gnt,
    output logic [fetch_pkg::NUM_PORTS-1:0]             rsp_valid,
    output fetch_pkg::rom_rsp_t                         rsp,
    output logic                                        rd,
    output fetch_pkg::rom_req_t                         rd_req,
    input  logic                                        rd_valid,
    input  fetch_pkg::rom_rsp_t                         rd_rsp
);

    // Port that is looked at first in the current cycle
    fetch_pkg::port_t pri_port;
    // Port that wins this cycle, meaningful only while rd is high
    fetch_pkg::port_t win_port;
    // Port whose read is in flight in the ROM
    fetch_pkg::port_t tag_port;

    // Scan the ports starting at the priority port and take the first request
    always_comb begin
        int   idx;
        logic found;
        idx      = 0;
        found    = 1'b0;
        win_port = pri_port;
        for (int i = 0; i < fetch_pkg::NUM_PORTS; i++) begin
            idx = (int'(pri_port) + i) % fetch_pkg::NUM_PORTS;
            if (!found && req[idx]) begin
                found    = 1'b1;
                win_port = fetch_pkg::port_t'(idx);
            end
        end
        gnt = '0;
        if (found) begin
            gnt[win_port] = 1'b1;
        end
        // The winner's request goes straight to the ROM
        rd     = found;
        rd_req = port_req[win_port];
    end

    // After a grant the port after the winner goes first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pri_port <= '0;
            tag_port <= '0;
        end else if (rd) begin
            pri_port <= fetch_pkg::port_t'((int'(win_port) + 1) % fetch_pkg::NUM_PORTS);
            tag_port <= win_port;
        end
    end

    // Data fans out to all ports and only the tagged port sees the strobe
    always_comb begin
        rsp_valid = '0;
        rsp_valid[tag_port] = rd_valid;
        rsp = rd_rsp;
    end

endmodule

`default_nettype wire

//--- hdl/weight_rom.sv
/*
 * Synchronous weight ROM with one read port and a one-cycle latency.
 * A read gives a layer and a row inside it, and the ROM returns that row
 * with a lane mask covering the weights that belong to the layer.
 */
`default_nettype none

module weight_rom (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd,
    input  fetch_pkg::rom_req_t rd_req,
    output logic                rd_valid,
    output fetch_pkg::rom_rsp_t rd_rsp
);

    // Whole image in layer-major order, lane 0 in the low byte
    cnn_weight_pkg::weight_vec_t mem [cnn_weight_pkg::ROM_DEPTH];

    // Row actually read after the offset and the clamp
    cnn_weight_pkg::vec_addr_t  rom_addr;
    // Lanes of the requested row that fall inside the layer
    cnn_weight_pkg::lane_mask_t lane_mask;

    initial begin
        $readmemh("weights.hex", mem);
    end

    // Translate the intra-layer row to a ROM row and work out the mask
    always_comb begin
        int abs_row;
        int first_weight;
        abs_row      = 0;
        first_weight = int'(rd_req.addr) * cnn_weight_pkg::VECTOR_SIZE;
        rom_addr     = '0;
        lane_mask    = '0;
        if (rd_req.layer < cnn_weight_pkg::NUM_LAYERS) begin
            abs_row = cnn_weight_pkg::LAYER_OFFSETS[rd_req.layer] + int'(rd_req.addr);
            // Rows past the end of the image read row 0 with nothing valid
            if (abs_row < cnn_weight_pkg::ROM_DEPTH) begin
                rom_addr = cnn_weight_pkg::vec_addr_t'(abs_row);
                for (int i = 0; i < cnn_weight_pkg::VECTOR_SIZE; i++) begin
                    lane_mask[i] = (first_weight + i) <
                                   cnn_weight_pkg::LAYER_WEIGHTS[rd_req.layer];
                end
            end
        end
    end

    // The strobe is the only control state in the ROM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd;
        end
    end

    // Register the row and zero every lane outside the layer
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_rsp.mask <= lane_mask;
            for (int i = 0; i < cnn_weight_pkg::VECTOR_SIZE; i++) begin
                if (lane_mask[i]) begin
                    rd_rsp.data[i*cnn_weight_pkg::WEIGHT_W +: cnn_weight_pkg::WEIGHT_W] <=
                        mem[rom_addr][i*cnn_weight_pkg::WEIGHT_W +: cnn_weight_pkg::WEIGHT_W];
                end else begin
                    rd_rsp.data[i*cnn_weight_pkg::WEIGHT_W +: cnn_weight_pkg::WEIGHT_W] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
/*
 * Types for moving weight rows between the engines, the arbiter and the ROM.
 * Also holds the encoding of the engine FSM states.
 */
`default_nettype none

package fetch_pkg;

    // Peer dot-product engines sharing the ROM read port
    localparam int NUM_PORTS = 2;

    // Index of one requesting engine
    typedef logic [0:0] port_t;

    // A read names the layer and the row inside that layer
    typedef struct packed {
        cnn_weight_pkg::layer_t    layer;
        cnn_weight_pkg::vec_addr_t addr;
    } rom_req_t;

    // The returned row with invalid lanes already zeroed
    typedef struct packed {
        cnn_weight_pkg::weight_vec_t data;
        cnn_weight_pkg::lane_mask_t  mask;
    } rom_rsp_t;

    // Engine FSM states
    // IDLE waits for start and STREAM issues one row per grant
    // DRAIN waits for the final response and REPORT raises done
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        STREAM = 2'd1,
        DRAIN  = 2'd2,
        REPORT = 2'd3
    } engine_state_e;

endpackage

`default_nettype wire

//--- hdl/cnn_weight_pkg.sv
/*
 * Layer geometry and data types for the CNN weight subsystem.
 * Every weight table the ROM, the engines and the testbench share is
 * derived here from the kernel and channel tables.
 */
`default_nettype none

package cnn_weight_pkg;

    // Width of one weight or activation lane
    localparam int WEIGHT_W = 8;
    // Width of the dot-product accumulator
    localparam int ACC_W = 24;

    // Weights delivered per ROM row
    localparam int VECTOR_SIZE = 4;

    // Number of layers stored back to back in the ROM
    localparam int NUM_LAYERS = 3;

    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [WEIGHT_W-1:0] act_t;
    // 24 bits hold 36 full-scale 16-bit products with room to spare
    typedef logic signed [ACC_W-1:0] acc_t;

    // Lane 0 occupies the low byte of every vector
    typedef logic [WEIGHT_W*VECTOR_SIZE-1:0] weight_vec_t;
    typedef logic [WEIGHT_W*VECTOR_SIZE-1:0] act_vec_t;
    typedef logic [VECTOR_SIZE-1:0] lane_mask_t;

    typedef logic [1:0] layer_t;
    // Row index inside a layer or inside the whole ROM
    typedef logic [3:0] vec_addr_t;

    // Square kernel edge length of each layer
    localparam int LAYER_KERNELS [NUM_LAYERS] = '{3, 1, 3};
    // Input channel count of each layer
    localparam int LAYER_CHANNELS [NUM_LAYERS] = '{4, 8, 2};

    // Weight count of each layer is kernel area times channels
    localparam int LAYER_WEIGHTS [NUM_LAYERS] = '{
        LAYER_KERNELS[0] * LAYER_KERNELS[0] * LAYER_CHANNELS[0],
        LAYER_KERNELS[1] * LAYER_KERNELS[1] * LAYER_CHANNELS[1],
        LAYER_KERNELS[2] * LAYER_KERNELS[2] * LAYER_CHANNELS[2]
    };

    // Rows per layer, with a partly filled last row when needed
    localparam int LAYER_VECTORS [NUM_LAYERS] = '{
        (LAYER_WEIGHTS[0] + VECTOR_SIZE - 1) / VECTOR_SIZE,
        (LAYER_WEIGHTS[1] + VECTOR_SIZE - 1) / VECTOR_SIZE,
        (LAYER_WEIGHTS[2] + VECTOR_SIZE - 1) / VECTOR_SIZE
    };

    // First ROM row of each layer in layer-major order
    localparam int LAYER_OFFSETS [NUM_LAYERS] = '{
        0,
        LAYER_VECTORS[0],
        LAYER_VECTORS[0] + LAYER_VECTORS[1]
    };

    // Total number of rows in the ROM image
    localparam int ROM_DEPTH = LAYER_OFFSETS[NUM_LAYERS-1] + LAYER_VECTORS[NUM_LAYERS-1];

endpackage

`default_nettype wire
